//--- hdl/idu_pkg.sv
// decode stage package with widths, opcodes, control encodings and funct constants
package idu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [3:0]      byte_mask_t;

  localparam word_t PC_STEP = 32'd4;

  // major opcodes
  localparam opcode_t LOAD   = 7'b0000011;
  localparam opcode_t OP_IMM = 7'b0010011;
  localparam opcode_t AUIPC  = 7'b0010111;
  localparam opcode_t STORE  = 7'b0100011;
  localparam opcode_t OP     = 7'b0110011;
  localparam opcode_t LUI    = 7'b0110111;
  localparam opcode_t BRANCH = 7'b1100011;
  localparam opcode_t JALR   = 7'b1100111;
  localparam opcode_t JAL    = 7'b1101111;

  // funct7 of the M extension
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load/store access size funct3
  localparam logic [2:0] MEM_B  = 3'b000;
  localparam logic [2:0] MEM_H  = 3'b001;
  localparam logic [2:0] MEM_W  = 3'b010;
  localparam logic [2:0] MEM_BU = 3'b100;
  localparam logic [2:0] MEM_HU = 3'b101;

  typedef enum logic [2:0] {
    FMT_I, FMT_U, FMT_S, FMT_J, FMT_B, FMT_R, FMT_NONE
  } inst_fmt_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_MUL, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
    ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_PASS_IMM
  } alu_op_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic {SRC2_RS2, SRC2_IMM} src2_sel_e;

endpackage

//--- hdl/inst_decoder.sv
// instruction decoder turning opcode and funct fields into control fields
`timescale 1ns/10ps

module inst_decoder import idu_pkg::*; (
  input  word_t      instr_i,
  output inst_fmt_e  fmt_o,
  output alu_op_e    alu_op_o,
  output src1_sel_e  src1_sel_o,
  output src2_sel_e  src2_sel_o,
  output pc_sel_e    pc_sel_o,
  output wb_sel_e    wb_sel_o,
  output logic       reg_write_en_o,
  output logic       mem_read_o,
  output logic       mem_write_o,
  output logic       mem_signed_o,
  output byte_mask_t wmask_o,
  output word_t      rmask_o,
  output reg_addr_t  rd_o,
  output reg_addr_t  rs1_o,
  output reg_addr_t  rs2_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign rd_o  = instr_i[11:7];
  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];

  always_comb begin
    case (opcode)
      LOAD, OP_IMM, JALR: fmt_o = FMT_I;
      LUI, AUIPC:         fmt_o = FMT_U;
      STORE:              fmt_o = FMT_S;
      JAL:                fmt_o = FMT_J;
      BRANCH:             fmt_o = FMT_B;
      OP:                 fmt_o = FMT_R;
      default:            fmt_o = FMT_NONE;
    endcase
  end

  always_comb begin
    alu_op_o = ALU_ADD;
    case (opcode)
      LUI: alu_op_o = ALU_PASS_IMM;
      OP_IMM: begin
        case (funct3)
          3'b001: alu_op_o = ALU_SLL;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          3'b101: begin
            // srai is told apart from srli by bit 30
            if (instr_i[30]) begin
              alu_op_o = ALU_SRA;
            end else begin
              alu_op_o = ALU_SRL;
            end
          end
          default: alu_op_o = ALU_ADD;
        endcase
      end
      OP: begin
        if (funct7 == F7_MULDIV) begin
          case (funct3)
            3'b000:  alu_op_o = ALU_MUL;
            3'b011:  alu_op_o = ALU_MULHU;
            3'b100:  alu_op_o = ALU_DIV;
            3'b101:  alu_op_o = ALU_DIVU;
            3'b110:  alu_op_o = ALU_REM;
            3'b111:  alu_op_o = ALU_REMU;
            default: alu_op_o = ALU_MUL;
          endcase
        end else begin
          case (funct3)
            3'b000: begin
              if (instr_i[30]) begin
                alu_op_o = ALU_SUB;
              end else begin
                alu_op_o = ALU_ADD;
              end
            end
            3'b001: alu_op_o = ALU_SLL;
            3'b010: alu_op_o = ALU_SLT;
            3'b011: alu_op_o = ALU_SLTU;
            3'b100: alu_op_o = ALU_XOR;
            3'b101: begin
              if (instr_i[30]) begin
                alu_op_o = ALU_SRA;
              end else begin
                alu_op_o = ALU_SRL;
              end
            end
            3'b110:  alu_op_o = ALU_OR;
            default: alu_op_o = ALU_AND;
          endcase
        end
      end
      BRANCH: begin
        // compare op for the branch kind
        case (funct3)
          F3_BLT, F3_BGE:   alu_op_o = ALU_SLT;
          F3_BLTU, F3_BGEU: alu_op_o = ALU_SLTU;
          default:          alu_op_o = ALU_SUB;
        endcase
      end
      default: alu_op_o = ALU_ADD;
    endcase
  end

  always_comb begin
    src1_sel_o = SRC1_RS1;
    src2_sel_o = SRC2_RS2;
    pc_sel_o   = PC_SEQ;
    wb_sel_o   = WB_ALU;
    case (opcode)
      AUIPC: begin
        src1_sel_o = SRC1_PC;
        src2_sel_o = SRC2_IMM;
      end
      JAL: begin
        src1_sel_o = SRC1_PC;
        src2_sel_o = SRC2_IMM;
        pc_sel_o   = PC_JAL;
        wb_sel_o   = WB_LINK;
      end
      JALR: begin
        src2_sel_o = SRC2_IMM;
        pc_sel_o   = PC_JALR;
        wb_sel_o   = WB_LINK;
      end
      LOAD: begin
        src2_sel_o = SRC2_IMM;
        wb_sel_o   = WB_MEM;
      end
      LUI, OP_IMM, STORE: src2_sel_o = SRC2_IMM;
      BRANCH:             pc_sel_o   = PC_BRANCH;
      default: ;
    endcase
  end

  assign reg_write_en_o = !(fmt_o inside {FMT_S, FMT_B, FMT_NONE});
  assign mem_read_o     = (opcode == LOAD);
  assign mem_write_o    = (opcode == STORE);

  // masks only for memory ops, zero otherwise
  always_comb begin
    wmask_o      = '0;
    rmask_o      = '0;
    mem_signed_o = 1'b0;
    if (mem_write_o) begin
      case (funct3)
        MEM_B:   wmask_o = 4'b0001;
        MEM_H:   wmask_o = 4'b0011;
        default: wmask_o = 4'b1111;
      endcase
    end
    if (mem_read_o) begin
      case (funct3)
        MEM_B, MEM_BU: rmask_o = 32'h0000_00ff;
        MEM_H, MEM_HU: rmask_o = 32'h0000_ffff;
        default:       rmask_o = 32'hffff_ffff;
      endcase
      mem_signed_o = (funct3 == MEM_B) || (funct3 == MEM_H);
    end
  end

endmodule

//--- hdl/imm_gen.sv
// immediate generator building the sign-extended immediate per format
`timescale 1ns/10ps

module imm_gen import idu_pkg::*; (
  input  word_t     instr_i,
  input  inst_fmt_e fmt_i,
  output word_t     imm_o
);

  word_t i_imm;
  word_t u_imm;
  word_t s_imm;
  word_t j_imm;
  word_t b_imm;

  assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
  assign u_imm = {instr_i[31:12], 12'b0};
  assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // j and b drop bit 0, always even
  assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

  always_comb begin
    case (fmt_i)
      FMT_I:   imm_o = i_imm;
      FMT_U:   imm_o = u_imm;
      FMT_S:   imm_o = s_imm;
      FMT_J:   imm_o = j_imm;
      FMT_B:   imm_o = b_imm;
      default: imm_o = '0;
    endcase
  end

endmodule

//--- hdl/operand_hazard.sv
// operand select with execute/write-back forwarding and the load/store stall
`timescale 1ns/10ps

module operand_hazard import idu_pkg::*; (
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  word_t     pc_i,
  input  word_t     imm_i,
  input  src1_sel_e src1_sel_i,
  input  src2_sel_e src2_sel_i,
  input  logic      exu_valid_i,
  input  logic      wbu_valid_i,
  input  logic      lsu_valid_i,
  input  reg_addr_t exu_rd_i,
  input  reg_addr_t wbu_rd_i,
  input  reg_addr_t lsu_rd_i,
  input  word_t     exu_wd_i,
  input  word_t     wbu_wd_i,
  output word_t     rs1_val_o,
  output word_t     rs2_val_o,
  output word_t     src1_o,
  output word_t     src2_o,
  output logic      stall_o
);

  // execute is younger, so it wins over write-back
  always_comb begin
    if (exu_valid_i && rs1_i != '0 && exu_rd_i == rs1_i) begin
      rs1_val_o = exu_wd_i;
    end else if (wbu_valid_i && rs1_i != '0 && wbu_rd_i == rs1_i) begin
      rs1_val_o = wbu_wd_i;
    end else begin
      rs1_val_o = rs1_data_i;
    end
  end

  always_comb begin
    if (exu_valid_i && rs2_i != '0 && exu_rd_i == rs2_i) begin
      rs2_val_o = exu_wd_i;
    end else if (wbu_valid_i && rs2_i != '0 && wbu_rd_i == rs2_i) begin
      rs2_val_o = wbu_wd_i;
    end else begin
      rs2_val_o = rs2_data_i;
    end
  end

  assign src1_o = (src1_sel_i == SRC1_PC) ? pc_i : rs1_val_o;
  assign src2_o = (src2_sel_i == SRC2_IMM) ? imm_i : rs2_val_o;

  // load result not ready yet
  assign stall_o = lsu_valid_i && (lsu_rd_i != '0) &&
                   ((lsu_rd_i == rs1_i) || (lsu_rd_i == rs2_i));

endmodule

//--- hdl/next_pc_unit.sv
// branch compare and next-pc selection
`timescale 1ns/10ps

module next_pc_unit import idu_pkg::*; (
  input  word_t      pc_i,
  input  word_t      imm_i,
  input  word_t      rs1_val_i,
  input  word_t      rs2_val_i,
  input  pc_sel_e    pc_sel_i,
  input  logic [2:0] funct3_i,
  output word_t      next_pc_o
);

  logic  eq;
  logic  lt;
  logic  ltu;
  logic  taken;
  word_t jalr_sum;

  assign eq  = (rs1_val_i == rs2_val_i);
  assign lt  = ($signed(rs1_val_i) < $signed(rs2_val_i));
  assign ltu = (rs1_val_i < rs2_val_i);

  always_comb begin
    case (funct3_i)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt;
      F3_BGE:  taken = !lt;
      F3_BLTU: taken = ltu;
      F3_BGEU: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_val_i + imm_i;

  always_comb begin
    case (pc_sel_i)
      PC_BRANCH: next_pc_o = taken ? pc_i + imm_i : pc_i + PC_STEP;
      PC_JAL:    next_pc_o = pc_i + imm_i;
      // target is always halfword aligned
      PC_JALR:   next_pc_o = {jalr_sum[XLEN-1:1], 1'b0};
      default:   next_pc_o = pc_i + PC_STEP;
    endcase
  end

endmodule

//--- hdl/idu_fsm.sv
// accept/decode state machine driving the handshake levels and the capture pulse
`timescale 1ns/10ps

module idu_fsm import idu_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic in_valid_i,
  input  logic stall_i,
  input  logic out_ready_i,
  output logic capture_o,
  output logic in_ready_o,
  output logic out_valid_o,
  output logic pc_write_en_o
);

  typedef enum logic {IDLE, DECODE} state_e;

  state_e state;
  state_e state_nxt;

  always_comb begin
    case (state)
      IDLE: begin
        if (in_valid_i) begin
          state_nxt = DECODE;
        end else begin
          state_nxt = IDLE;
        end
      end
      default: begin
        if (out_valid_o && out_ready_i) begin
          state_nxt = IDLE;
        end else begin
          state_nxt = DECODE;
        end
      end
    endcase
  end

  // once per instruction, on the first edge without a load conflict
  assign capture_o = (state_nxt == DECODE) && !out_valid_o && !stall_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      out_valid_o <= 1'b0;
    end else begin
      state <= state_nxt;
      if (capture_o) begin
        out_valid_o <= 1'b1;
      end else if (out_valid_o && out_ready_i) begin
        out_valid_o <= 1'b0;
      end
    end
  end

  assign in_ready_o    = (state == DECODE);
  assign pc_write_en_o = out_valid_o && out_ready_i;

endmodule

//--- hdl/idu_out_reg.sv
// output register bank holding the decoded bundle for the execute stage
`timescale 1ns/10ps

module idu_out_reg import idu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       capture_i,
  input  word_t      instr_i,
  input  word_t      pc_i,
  input  word_t      imm_i,
  input  word_t      src1_i,
  input  word_t      src2_i,
  input  word_t      next_pc_i,
  input  reg_addr_t  rd_i,
  input  alu_op_e    alu_op_i,
  input  wb_sel_e    wb_sel_i,
  input  logic       reg_write_en_i,
  input  logic       mem_read_i,
  input  logic       mem_write_i,
  input  logic       mem_signed_i,
  input  byte_mask_t wmask_i,
  input  word_t      rmask_i,
  output word_t      instr_o,
  output word_t      pc_o,
  output word_t      imm_o,
  output word_t      src1_o,
  output word_t      src2_o,
  output word_t      next_pc_o,
  output reg_addr_t  rd_o,
  output alu_op_e    alu_op_o,
  output wb_sel_e    wb_sel_o,
  output logic       reg_write_en_o,
  output logic       mem_read_o,
  output logic       mem_write_o,
  output logic       mem_signed_o,
  output byte_mask_t wmask_o,
  output word_t      rmask_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      instr_o        <= '0;
      pc_o           <= '0;
      imm_o          <= '0;
      src1_o         <= '0;
      src2_o         <= '0;
      next_pc_o      <= '0;
      rd_o           <= '0;
      alu_op_o       <= ALU_ADD;
      wb_sel_o       <= WB_ALU;
      reg_write_en_o <= 1'b0;
      mem_read_o     <= 1'b0;
      mem_write_o    <= 1'b0;
      mem_signed_o   <= 1'b0;
      wmask_o        <= '0;
      rmask_o        <= '0;
    end else if (capture_i) begin
      instr_o        <= instr_i;
      pc_o           <= pc_i;
      imm_o          <= imm_i;
      src1_o         <= src1_i;
      src2_o         <= src2_i;
      next_pc_o      <= next_pc_i;
      rd_o           <= rd_i;
      alu_op_o       <= alu_op_i;
      wb_sel_o       <= wb_sel_i;
      reg_write_en_o <= reg_write_en_i;
      mem_read_o     <= mem_read_i;
      mem_write_o    <= mem_write_i;
      mem_signed_o   <= mem_signed_i;
      wmask_o        <= wmask_i;
      rmask_o        <= rmask_i;
    end
  end

endmodule

//--- hdl/idu_top.sv
// decode stage top level connecting decoder, operand path, next-pc unit and FSM
`timescale 1ns/10ps

module idu_top import idu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  word_t      instr_i,
  input  word_t      pc_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output logic       pc_write_en_o,
  input  logic       exu_valid_i,
  input  reg_addr_t  exu_rd_i,
  input  word_t      exu_wd_i,
  input  logic       wbu_valid_i,
  input  reg_addr_t  wbu_rd_i,
  input  word_t      wbu_wd_i,
  input  logic       lsu_valid_i,
  input  reg_addr_t  lsu_rd_i,
  input  word_t      rs1_data_i,
  input  word_t      rs2_data_i,
  output reg_addr_t  rs1_o,
  output reg_addr_t  rs2_o,
  output word_t      instr_o,
  output word_t      pc_o,
  output word_t      imm_o,
  output word_t      src1_o,
  output word_t      src2_o,
  output word_t      next_pc_o,
  output reg_addr_t  rd_o,
  output alu_op_e    alu_op_o,
  output wb_sel_e    wb_sel_o,
  output logic       reg_write_en_o,
  output logic       mem_read_o,
  output logic       mem_write_o,
  output logic       mem_signed_o,
  output byte_mask_t wmask_o,
  output word_t      rmask_o
);

  inst_fmt_e  fmt;
  alu_op_e    alu_op;
  src1_sel_e  src1_sel;
  src2_sel_e  src2_sel;
  pc_sel_e    pc_sel;
  wb_sel_e    wb_sel;
  logic       reg_write_en;
  logic       mem_read;
  logic       mem_write;
  logic       mem_signed;
  byte_mask_t wmask;
  word_t      rmask;
  reg_addr_t  rd;
  word_t      imm;
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      src1;
  word_t      src2;
  word_t      next_pc;
  logic       stall;
  logic       capture;

  idu_fsm i_idu_fsm (
    .clk           (clk),
    .rst           (rst),
    .in_valid_i    (in_valid_i),
    .stall_i       (stall),
    .out_ready_i   (out_ready_i),
    .capture_o     (capture),
    .in_ready_o    (in_ready_o),
    .out_valid_o   (out_valid_o),
    .pc_write_en_o (pc_write_en_o)
  );

  inst_decoder i_inst_decoder (
    .instr_i        (instr_i),
    .fmt_o          (fmt),
    .alu_op_o       (alu_op),
    .src1_sel_o     (src1_sel),
    .src2_sel_o     (src2_sel),
    .pc_sel_o       (pc_sel),
    .wb_sel_o       (wb_sel),
    .reg_write_en_o (reg_write_en),
    .mem_read_o     (mem_read),
    .mem_write_o    (mem_write),
    .mem_signed_o   (mem_signed),
    .wmask_o        (wmask),
    .rmask_o        (rmask),
    .rd_o           (rd),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o)
  );

  imm_gen i_imm_gen (
    .instr_i (instr_i),
    .fmt_i   (fmt),
    .imm_o   (imm)
  );

  operand_hazard i_operand_hazard (
    .rs1_i       (rs1_o),
    .rs2_i       (rs2_o),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .pc_i        (pc_i),
    .imm_i       (imm),
    .src1_sel_i  (src1_sel),
    .src2_sel_i  (src2_sel),
    .exu_valid_i (exu_valid_i),
    .wbu_valid_i (wbu_valid_i),
    .lsu_valid_i (lsu_valid_i),
    .exu_rd_i    (exu_rd_i),
    .wbu_rd_i    (wbu_rd_i),
    .lsu_rd_i    (lsu_rd_i),
    .exu_wd_i    (exu_wd_i),
    .wbu_wd_i    (wbu_wd_i),
    .rs1_val_o   (rs1_val),
    .rs2_val_o   (rs2_val),
    .src1_o      (src1),
    .src2_o      (src2),
    .stall_o     (stall)
  );

  // branch compare uses the forwarded register values
  next_pc_unit i_next_pc_unit (
    .pc_i      (pc_i),
    .imm_i     (imm),
    .rs1_val_i (rs1_val),
    .rs2_val_i (rs2_val),
    .pc_sel_i  (pc_sel),
    .funct3_i  (instr_i[14:12]),
    .next_pc_o (next_pc)
  );

  idu_out_reg i_idu_out_reg (
    .clk            (clk),
    .rst            (rst),
    .capture_i      (capture),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .imm_i          (imm),
    .src1_i         (src1),
    .src2_i         (src2),
    .next_pc_i      (next_pc),
    .rd_i           (rd),
    .alu_op_i       (alu_op),
    .wb_sel_i       (wb_sel),
    .reg_write_en_i (reg_write_en),
    .mem_read_i     (mem_read),
    .mem_write_i    (mem_write),
    .mem_signed_i   (mem_signed),
    .wmask_i        (wmask),
    .rmask_i        (rmask),
    .instr_o        (instr_o),
    .pc_o           (pc_o),
    .imm_o          (imm_o),
    .src1_o         (src1_o),
    .src2_o         (src2_o),
    .next_pc_o      (next_pc_o),
    .rd_o           (rd_o),
    .alu_op_o       (alu_op_o),
    .wb_sel_o       (wb_sel_o),
    .reg_write_en_o (reg_write_en_o),
    .mem_read_o     (mem_read_o),
    .mem_write_o    (mem_write_o),
    .mem_signed_o   (mem_signed_o),
    .wmask_o        (wmask_o),
    .rmask_o        (rmask_o)
  );

endmodule

//--- sim/tb_idu.sv
// testbench for the decode stage, driven from the case file with handshake checks
`timescale 1ns/10ps

module tb_idu import idu_pkg::*; ();

  localparam int MAX_CASES = 64;
  localparam int CLK_PERIOD = 40;
  localparam int CASE_CYCLES = 40;

  logic       clk;
  logic       rst;
  word_t      instr_i;
  word_t      pc_i;
  logic       in_valid_i;
  logic       in_ready_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       pc_write_en_o;
  logic       exu_valid_i;
  reg_addr_t  exu_rd_i;
  word_t      exu_wd_i;
  logic       wbu_valid_i;
  reg_addr_t  wbu_rd_i;
  word_t      wbu_wd_i;
  logic       lsu_valid_i;
  reg_addr_t  lsu_rd_i;
  word_t      rs1_data_i;
  word_t      rs2_data_i;
  reg_addr_t  rs1_o;
  reg_addr_t  rs2_o;
  word_t      instr_o;
  word_t      pc_o;
  word_t      imm_o;
  word_t      src1_o;
  word_t      src2_o;
  word_t      next_pc_o;
  reg_addr_t  rd_o;
  alu_op_e    alu_op_o;
  wb_sel_e    wb_sel_o;
  logic       reg_write_en_o;
  logic       mem_read_o;
  logic       mem_write_o;
  logic       mem_signed_o;
  byte_mask_t wmask_o;
  word_t      rmask_o;

  // case table, one entry per line of the case file
  logic [8*16-1:0] names [MAX_CASES];
  word_t      instr_a [MAX_CASES];
  word_t      pc_a [MAX_CASES];
  word_t      rs1d_a [MAX_CASES];
  word_t      rs2d_a [MAX_CASES];
  logic       exu_v_a [MAX_CASES];
  reg_addr_t  exu_rd_a [MAX_CASES];
  word_t      exu_wd_a [MAX_CASES];
  logic       wbu_v_a [MAX_CASES];
  reg_addr_t  wbu_rd_a [MAX_CASES];
  word_t      wbu_wd_a [MAX_CASES];
  logic       lsu_v_a [MAX_CASES];
  reg_addr_t  lsu_rd_a [MAX_CASES];
  int         lsu_cyc_a [MAX_CASES];
  logic [4:0] alu_e [MAX_CASES];
  word_t      imm_e [MAX_CASES];
  word_t      src1_e [MAX_CASES];
  word_t      src2_e [MAX_CASES];
  reg_addr_t  rd_e [MAX_CASES];
  logic       we_e [MAX_CASES];
  word_t      next_e [MAX_CASES];
  byte_mask_t wmask_e [MAX_CASES];
  word_t      rmask_e [MAX_CASES];
  logic       signed_e [MAX_CASES];
  logic       mread_e [MAX_CASES];
  logic       mwrite_e [MAX_CASES];

  int         n_cases = 0;
  logic       loaded = 1'b0;
  int         mismatches = 0;
  int         other_errs = 0;
  int         pulses = 0;
  integer     seed = 32'h8b9e;
  string      cur_name;

  idu_top i_idu_top (
    .clk            (clk),
    .rst            (rst),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .pc_write_en_o  (pc_write_en_o),
    .exu_valid_i    (exu_valid_i),
    .exu_rd_i       (exu_rd_i),
    .exu_wd_i       (exu_wd_i),
    .wbu_valid_i    (wbu_valid_i),
    .wbu_rd_i       (wbu_rd_i),
    .wbu_wd_i       (wbu_wd_i),
    .lsu_valid_i    (lsu_valid_i),
    .lsu_rd_i       (lsu_rd_i),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .instr_o        (instr_o),
    .pc_o           (pc_o),
    .imm_o          (imm_o),
    .src1_o         (src1_o),
    .src2_o         (src2_o),
    .next_pc_o      (next_pc_o),
    .rd_o           (rd_o),
    .alu_op_o       (alu_op_o),
    .wb_sel_o       (wb_sel_o),
    .reg_write_en_o (reg_write_en_o),
    .mem_read_o     (mem_read_o),
    .mem_write_o    (mem_write_o),
    .mem_signed_o   (mem_signed_o),
    .wmask_o        (wmask_o),
    .rmask_o        (rmask_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // transfer pulses, sampled mid-cycle
  always @(negedge clk) begin
    if (pc_write_en_o) begin
      pulses = pulses + 1;
    end
  end

  task automatic tick;
    @(posedge clk);
    #2;
  endtask

  task automatic check_word(input string field, input word_t exp, input word_t act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch case %0s %0s expected %h actual %h", cur_name, field, exp, act);
    end
  endtask

  task automatic check_alu_op(input alu_op_e exp, input alu_op_e act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch case %0s alu_op expected %0s actual %0s",
               cur_name, exp.name(), act.name());
    end
  endtask

  task automatic check_wb_sel(input wb_sel_e exp, input wb_sel_e act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch case %0s wb_sel expected %0s actual %0s",
               cur_name, exp.name(), act.name());
    end
  endtask

  task automatic check_reg_addr(input string field, input reg_addr_t exp, input reg_addr_t act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch case %0s %0s expected %0d actual %0d", cur_name, field, exp, act);
    end
  endtask

  task automatic check_mask(input byte_mask_t exp, input byte_mask_t act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch case %0s wmask expected %b actual %b", cur_name, exp, act);
    end
  endtask

  task automatic check_flag(input string field, input logic exp, input logic act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch case %0s %0s expected %b actual %b", cur_name, field, exp, act);
    end
  endtask

  task automatic report(input string msg);
    other_errs++;
    $display("Error in case %0s: %0s", cur_name, msg);
  endtask

  // loads write back memory data, jumps write back the link address
  function automatic wb_sel_e expected_wb_sel(input word_t instr);
    case (instr[6:0])
      LOAD:      return WB_MEM;
      JAL, JALR: return WB_LINK;
      default:   return WB_ALU;
    endcase
  endfunction

  task automatic check_bundle(input int i);
    check_word("instr", instr_a[i], instr_o);
    check_word("pc", pc_a[i], pc_o);
    check_alu_op(alu_op_e'(alu_e[i]), alu_op_o);
    check_word("imm", imm_e[i], imm_o);
    check_word("src1", src1_e[i], src1_o);
    check_word("src2", src2_e[i], src2_o);
    check_reg_addr("rd", rd_e[i], rd_o);
    check_reg_addr("rs1", instr_a[i][19:15], rs1_o);
    check_reg_addr("rs2", instr_a[i][24:20], rs2_o);
    check_wb_sel(expected_wb_sel(instr_a[i]), wb_sel_o);
    check_flag("reg_write_en", we_e[i], reg_write_en_o);
    check_word("next_pc", next_e[i], next_pc_o);
    check_mask(wmask_e[i], wmask_o);
    check_word("rmask", rmask_e[i], rmask_o);
    check_flag("mem_signed", signed_e[i], mem_signed_o);
    check_flag("mem_read", mread_e[i], mem_read_o);
    check_flag("mem_write", mwrite_e[i], mem_write_o);
  endtask

  task automatic load_cases;
    int    fd;
    int    r;
    string line;
    fd = $fopen("sim/idu_cases.txt", "r");
    if (fd == 0) begin
      cur_name = "setup";
      report("case file sim/idu_cases.txt could not be opened");
    end else begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        r = $fgets(line, fd);
        if (r > 0 && line.len() > 4 && line[0] != "#") begin
          r = $sscanf(line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h %h %h %h %h %h %h %h",
            names[n_cases], instr_a[n_cases], pc_a[n_cases], rs1d_a[n_cases],
            rs2d_a[n_cases], exu_v_a[n_cases], exu_rd_a[n_cases], exu_wd_a[n_cases],
            wbu_v_a[n_cases], wbu_rd_a[n_cases], wbu_wd_a[n_cases], lsu_v_a[n_cases],
            lsu_rd_a[n_cases], lsu_cyc_a[n_cases], alu_e[n_cases], imm_e[n_cases],
            src1_e[n_cases], src2_e[n_cases], rd_e[n_cases], we_e[n_cases],
            next_e[n_cases], wmask_e[n_cases], rmask_e[n_cases], signed_e[n_cases],
            mread_e[n_cases], mwrite_e[n_cases]);
          if (r == 26) begin
            n_cases++;
          end else begin
            cur_name = "setup";
            report("malformed line in case file");
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  task automatic run_case(input int i);
    logic conflict;
    int   wait_n;
    int   exp_wait;
    int   hold;
    int   pulses_before;
    cur_name = names[i];
    instr_i     = instr_a[i];
    pc_i        = pc_a[i];
    rs1_data_i  = rs1d_a[i];
    rs2_data_i  = rs2d_a[i];
    exu_valid_i = exu_v_a[i];
    exu_rd_i    = exu_rd_a[i];
    exu_wd_i    = exu_wd_a[i];
    wbu_valid_i = wbu_v_a[i];
    wbu_rd_i    = wbu_rd_a[i];
    wbu_wd_i    = wbu_wd_a[i];
    lsu_valid_i = lsu_v_a[i];
    lsu_rd_i    = lsu_rd_a[i];
    in_valid_i  = 1'b1;
    out_ready_i = 1'b0;
    pulses_before = pulses;
    // x0 is never a conflict
    conflict = lsu_v_a[i] && (lsu_rd_a[i] != 5'd0) &&
               ((lsu_rd_a[i] == instr_a[i][19:15]) || (lsu_rd_a[i] == instr_a[i][24:20]));
    for (int k = 0; k < lsu_cyc_a[i]; k++) begin
      tick();
      if (conflict && out_valid_o) begin
        report("out_valid_o rose while the load/store conflict was active");
      end else if (!conflict && lsu_v_a[i] && !out_valid_o) begin
        report("out_valid_o was held back by a load/store entry that is no conflict");
      end
    end
    lsu_valid_i = 1'b0;
    exp_wait = (lsu_v_a[i] && !conflict && lsu_cyc_a[i] > 0) ? 0 : 1;
    wait_n = 0;
    while (!out_valid_o && wait_n < 8) begin
      tick();
      wait_n++;
    end
    if (!out_valid_o) begin
      report("out_valid_o never rose");
    end else begin
      if (wait_n != exp_wait) begin
        report($sformatf("out_valid_o rose after %0d cycles instead of %0d", wait_n, exp_wait));
      end
      if (!in_ready_o) begin
        report("in_ready_o low while an instruction is held");
      end
      check_bundle(i);
      hold = $random(seed) & 3;
      repeat (hold) begin
        tick();
        if (!out_valid_o) begin
          report("out_valid_o dropped under back-pressure");
        end
        check_bundle(i);
      end
      out_ready_i = 1'b1;
      #1;
      if (!pc_write_en_o) begin
        report("pc_write_en_o low in the transfer cycle");
      end
      tick();
      out_ready_i = 1'b0;
      in_valid_i  = 1'b0;
      if (out_valid_o || in_ready_o) begin
        report("handshake did not return to idle after the transfer");
      end
      if (pulses - pulses_before != 1) begin
        report($sformatf("pc_write_en_o pulsed %0d times", pulses - pulses_before));
      end
    end
  endtask

  initial begin
    rst         = 1'b1;
    instr_i     = '0;
    pc_i        = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    exu_valid_i = 1'b0;
    exu_rd_i    = '0;
    exu_wd_i    = '0;
    wbu_valid_i = 1'b0;
    wbu_rd_i    = '0;
    wbu_wd_i    = '0;
    lsu_valid_i = 1'b0;
    lsu_rd_i    = '0;
    rs1_data_i  = '0;
    rs2_data_i  = '0;
    load_cases();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    cur_name = "reset";
    if (out_valid_o || in_ready_o || pc_write_en_o) begin
      report("handshake outputs not low after reset");
    end
    if (n_cases == 0) begin
      report("no cases were loaded");
    end
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    tick();
    $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog scaled to the number of cases
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(n_cases + 2) * CASE_CYCLES * CLK_PERIOD;
    #(limit_ns);
    other_errs++;
    $display("Error: timeout, the run did not finish within %0d ns", limit_ns);
    $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- sim/idu_cases.txt
# name instr pc rs1_data rs2_data exu_v exu_rd exu_wd wbu_v wbu_rd wbu_wd lsu_v lsu_rd lsu_cycles
# then expected: alu_op imm src1 src2 rd reg_we next_pc wmask rmask mem_signed mem_read mem_write
add_r 002081b3 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 11111111 22222222 3 1 1004 0 0 0 0 0
sub_r 402081b3 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 1 0 11111111 22222222 3 1 1004 0 0 0 0 0
mul_r 022081b3 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 2 0 11111111 22222222 3 1 1004 0 0 0 0 0
divu_r 0220d1b3 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 5 0 11111111 22222222 3 1 1004 0 0 0 0 0
sra_r 4020d1b3 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 f 0 11111111 22222222 3 1 1004 0 0 0 0 0
srai 4030d293 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 f 403 11111111 403 5 1 1004 0 0 0 0 0
slli 00709293 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 d 7 11111111 7 5 1 1004 0 0 0 0 0
lui 123453b7 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 10 12345000 11111111 12345000 7 1 1004 0 0 0 0 0
auipc fffff397 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 fffff000 1000 fffff000 7 1 1004 0 0 0 0 0
lb ffc08303 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 fffffffc 11111111 fffffffc 6 1 1004 0 ff 1 1 0
lhu 0080d303 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 8 11111111 8 6 1 1004 0 ffff 0 1 0
sw 0020aa23 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 14 11111111 14 14 0 1004 f 0 0 0 1
sb fe208fa3 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 ffffffff 11111111 ffffffff 1f 0 1004 1 0 0 0 1
fwd_exu 002081b3 1000 11111111 22222222 1 1 aaaa0001 1 1 bbbb0001 0 0 0 0 0 aaaa0001 22222222 3 1 1004 0 0 0 0 0
fwd_wbu 002081b3 1000 11111111 22222222 1 4 aaaa0004 1 1 bbbb0001 0 0 0 0 0 bbbb0001 22222222 3 1 1004 0 0 0 0 0
fwd_x0 002001b3 1000 0 22222222 1 0 aaaa0000 1 0 bbbb0000 0 0 0 0 0 0 22222222 3 1 1004 0 0 0 0 0
beq_t 00208863 1000 5 5 0 0 0 0 0 0 0 0 0 1 10 5 5 10 0 1010 0 0 0 0 0
bne_nt 00209863 1000 5 5 0 0 0 0 0 0 0 0 0 1 10 5 5 10 0 1004 0 0 0 0 0
blt_t fe20cce3 1000 ffffffff 1 0 0 0 0 0 0 0 0 0 8 fffffff8 ffffffff 1 19 0 ff8 0 0 0 0 0
bgeu_nt fe20fce3 1000 1 ffffffff 0 0 0 0 0 0 0 0 0 9 fffffff8 1 ffffffff 19 0 1004 0 0 0 0 0
jal 100000ef 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 100 1000 100 1 1 1100 0 0 0 0 0
jalr 003280e7 1000 2000 22222222 0 0 0 0 0 0 0 0 0 0 3 2000 3 1 1 2002 0 0 0 0 0
stall_rs2 002081b3 1000 11111111 22222222 0 0 0 0 0 0 1 2 3 0 0 11111111 22222222 3 1 1004 0 0 0 0 0
stall_x0 002001b3 1000 0 22222222 0 0 0 0 0 0 1 0 3 0 0 0 22222222 3 1 1004 0 0 0 0 0

//--- files.f
hdl/idu_pkg.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/operand_hazard.sv
hdl/next_pc_unit.sv
hdl/idu_fsm.sv
hdl/idu_out_reg.sv
hdl/idu_top.sv
sim/tb_idu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --top-module tb_idu -f files.f -Mdir obj_dir -o sim_idu; then
  echo "build failed"
  exit 1
fi

if ! ./obj_dir/sim_idu > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  exit 0
else
  exit 1
fi
